// ==== common/xfer_pkg.sv ====
// transfer package
// command encoding and default widths shared by the sequencer, router and top
package xfer_pkg;

   // default datapath sizes, overridden through the top-level parameters
   parameter int DATA_W  = 32;  // word width
   parameter int SRAM_AW = 7;   // 128 sram words
   parameter int FR_AW   = 5;   // 32 registers

   // one command per start edge once the fill is done
   typedef enum logic [2:0] {
      CMD_IDLE       = 3'd0,  // no transfer, acknowledged right away
      CMD_TO_SRAM    = 3'd1,  // input word -> sram
      CMD_TO_FR      = 3'd2,  // input word -> register file
      CMD_FROM_SRAM  = 3'd3,  // sram -> rdata
      CMD_FROM_FR    = 3'd4,  // register file -> rdata
      CMD_FR_TO_SRAM = 3'd5,  // copy register -> sram word
      CMD_SRAM_TO_FR = 3'd6   // copy sram word -> register
   } xfer_cmd_e;

endpackage

// ==== memory/sram.sv ====
`timescale 1ns/1ns
// single-port sram
// synchronous write, registered read, depth set by the address width
module sram #(
   parameter int data_w  = xfer_pkg::DATA_W,
   parameter int sram_aw = xfer_pkg::SRAM_AW
) (
   input  logic               clk,
   input  logic               we,     // write at this edge
   input  logic               re,     // rdata valid next cycle
   input  logic [sram_aw-1:0] addr,
   input  logic [data_w-1:0]  wdata,
   output logic [data_w-1:0]  rdata
);

   localparam int depth = 1 << sram_aw;

   logic [data_w-1:0] mem [depth];  // word array

   // write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
   end

   // read port, holds the last word between reads
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[addr];
      end
   end

endmodule

// ==== memory/register_file.sv ====
`timescale 1ns/1ns
// register file
// 32 entries, register 0 hardwired to zero, whole array cleared on reset
module register_file #(
   parameter int data_w = xfer_pkg::DATA_W,
   parameter int fr_aw  = xfer_pkg::FR_AW
) (
   input  logic              clk,
   input  logic              rst,    // clears every entry
   input  logic              we,
   input  logic              re,
   input  logic [fr_aw-1:0]  addr,
   input  logic [data_w-1:0] wdata,
   output logic [data_w-1:0] rdata
);

   localparam int entries = 1 << fr_aw;

   logic [data_w-1:0] regs [entries];
   logic              addr_zero;

   assign addr_zero = addr == '0;  // mips $zero

   // write side, writes to r0 are dropped
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < entries; i++) begin
            regs[i] <= '0;
         end
      end else if (we && !addr_zero) begin
         regs[addr] <= wdata;
      end
   end

   // registered read
   always_ff @(posedge clk) begin
      if (rst) begin
         rdata <= '0;
      end else if (re) begin
         rdata <= addr_zero ? '0 : regs[addr];  // r0 always reads zero
      end
   end

endmodule

// ==== logic/xfer_sequencer.sv ====
`timescale 1ns/1ns
// transfer sequencer
// fills the sram with the inverted-address pattern, then issues one command per start edge
module xfer_sequencer #(
   parameter int data_w  = xfer_pkg::DATA_W,
   parameter int sram_aw = xfer_pkg::SRAM_AW,
   parameter int fr_aw   = xfer_pkg::FR_AW
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                start,       // level, rising edge only
   input  xfer_pkg::xfer_cmd_e cmd,
   input  logic [sram_aw-1:0]  sram_addr,
   input  logic [fr_aw-1:0]    reg_addr,
   input  logic [data_w-1:0]   wdata,
   input  logic                op_done,     // end of the current command
   output logic                op_valid,    // one-cycle issue pulse
   output xfer_pkg::xfer_cmd_e op,
   output logic [sram_aw-1:0]  op_sram_addr,
   output logic [fr_aw-1:0]    op_reg_addr,
   output logic [data_w-1:0]   op_wdata,
   output logic                busy,
   output logic                init_done
);
   import xfer_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,   // waiting for the first start
      S_FILL,   // one sram write per cycle
      S_PAUSE,  // last write settles
      S_READY   // command mode
   } seq_state_e;

   seq_state_e         state;
   logic               start_q;
   logic               start_edge;
   logic [sram_aw:0]   fill_cnt;    // msb set once every word is issued
   logic [sram_aw-1:0] fill_addr;
   logic [data_w-1:0]  fill_word;
   logic               issue_fill;
   logic               issue_cmd;

   assign start_edge = start & ~start_q;
   assign fill_addr  = fill_cnt[sram_aw-1:0];
   assign fill_word  = {{(data_w-sram_aw){1'b0}}, ~fill_addr};  // inverse in low bits

   // first fill write goes out on the edge itself, so op_valid follows in one cycle
   assign issue_fill = (state == S_IDLE && start_edge) ||
                       (state == S_FILL && !fill_cnt[sram_aw]);
   // edges while busy are dropped
   assign issue_cmd  = state == S_READY && !busy && start_edge;

   always_ff @(posedge clk) begin
      if (rst) begin
         start_q <= 1'b0;
      end else begin
         start_q <= start;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= S_IDLE;
         fill_cnt  <= '0;
         op_valid  <= 1'b0;
         busy      <= 1'b0;
         init_done <= 1'b0;
      end else begin
         op_valid <= issue_fill | issue_cmd;
         if (issue_fill) begin
            fill_cnt <= fill_cnt + {{sram_aw{1'b0}}, 1'b1};
         end
         case (state)
            S_IDLE: begin
               if (start_edge) begin
                  state <= S_FILL;
                  busy  <= 1'b1;  // held through the whole fill
               end
            end
            S_FILL: begin
               // router acks each fill write, counted here instead
               if (fill_cnt[sram_aw]) begin
                  state <= S_PAUSE;
               end
            end
            S_PAUSE: begin
               state     <= S_READY;
               busy      <= 1'b0;
               init_done <= 1'b1;
            end
            S_READY: begin
               if (issue_cmd) begin
                  busy <= 1'b1;
               end else if (op_done) begin
                  busy <= 1'b0;  // falling edge marks the end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // op fields stay put until the next issue, router reads them in later steps
   always_ff @(posedge clk) begin
      if (issue_fill) begin
         op           <= CMD_TO_SRAM;
         op_sram_addr <= fill_addr;
         op_reg_addr  <= '0;
         op_wdata     <= fill_word;
      end else if (issue_cmd) begin
         op           <= cmd;
         op_sram_addr <= sram_addr;
         op_reg_addr  <= reg_addr;
         op_wdata     <= wdata;
      end
   end

endmodule

// ==== logic/bus_router.sv ====
`timescale 1ns/1ns
// bus router
// turns each op into sram and register-file strobes, stages copies, captures reads
module bus_router #(
   parameter int data_w  = xfer_pkg::DATA_W,
   parameter int sram_aw = xfer_pkg::SRAM_AW,
   parameter int fr_aw   = xfer_pkg::FR_AW
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                op_valid,
   input  xfer_pkg::xfer_cmd_e op,            // held until the next issue
   input  logic [sram_aw-1:0]  op_sram_addr,
   input  logic [fr_aw-1:0]    op_reg_addr,
   input  logic [data_w-1:0]   op_wdata,
   input  logic [data_w-1:0]   sram_rdata,
   input  logic [data_w-1:0]   fr_rdata,
   output logic                op_done,
   output logic                sram_we,
   output logic                sram_re,
   output logic [sram_aw-1:0]  sram_addr,
   output logic [data_w-1:0]   sram_wdata,
   output logic                fr_we,
   output logic                fr_re,
   output logic [fr_aw-1:0]    fr_addr,
   output logic [data_w-1:0]   fr_wdata,
   output logic [data_w-1:0]   rdata           // last word read
);
   import xfer_pkg::*;

   typedef enum logic [1:0] {
      R_IDLE,      // first step fires straight off op_valid
      R_RD_WAIT,   // memory output valid, capture into rdata
      R_CP_STAGE,  // capture source word
      R_CP_WRITE   // write destination from the stage
   } router_state_e;

   router_state_e     state;
   logic [data_w-1:0] stage_word;  // copy buffer
   logic              cp_write;

   assign cp_write = state == R_CP_WRITE;

   // first strobes come straight off the issue pulse, copy writes from the state
   assign sram_we = (op_valid && op == CMD_TO_SRAM) || (cp_write && op == CMD_FR_TO_SRAM);
   assign sram_re = op_valid && (op == CMD_FROM_SRAM || op == CMD_SRAM_TO_FR);
   assign fr_we   = (op_valid && op == CMD_TO_FR) || (cp_write && op == CMD_SRAM_TO_FR);
   assign fr_re   = op_valid && (op == CMD_FROM_FR || op == CMD_FR_TO_SRAM);

   assign sram_addr  = op_sram_addr;
   assign fr_addr    = op_reg_addr;
   assign sram_wdata = cp_write ? stage_word : op_wdata;
   assign fr_wdata   = cp_write ? stage_word : op_wdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= R_IDLE;
         op_done <= 1'b0;
         rdata   <= '0;  // display shows zeros after reset
      end else begin
         op_done <= 1'b0;
         case (state)
            R_IDLE: begin
               if (op_valid) begin
                  case (op)
                     CMD_FROM_SRAM, CMD_FROM_FR:   state <= R_RD_WAIT;
                     CMD_FR_TO_SRAM, CMD_SRAM_TO_FR: state <= R_CP_STAGE;
                     default:                       op_done <= 1'b1;  // writes and idle
                  endcase
               end
            end
            R_RD_WAIT: begin
               rdata   <= (op == CMD_FROM_SRAM) ? sram_rdata : fr_rdata;
               op_done <= 1'b1;
               state   <= R_IDLE;
            end
            R_CP_STAGE: state <= R_CP_WRITE;
            R_CP_WRITE: begin
               op_done <= 1'b1;
               state   <= R_IDLE;
            end
            default: state <= R_IDLE;
         endcase
      end
   end

   // source word of a copy, valid the cycle after its read strobe
   always_ff @(posedge clk) begin
      if (state == R_CP_STAGE) begin
         stage_word <= (op == CMD_SRAM_TO_FR) ? sram_rdata : fr_rdata;
      end
   end

endmodule

// ==== logic/hex_display.sv ====
`timescale 1ns/1ns
// hex display
// six active-low seven-segment digits from the low 24 bits, segment a is bit 0
module hex_display #(
   parameter int data_w = xfer_pkg::DATA_W
) (
   input  logic [data_w-1:0] value,
   output logic [6:0]        hex0,   // lowest nibble
   output logic [6:0]        hex1,
   output logic [6:0]        hex2,
   output logic [6:0]        hex3,
   output logic [6:0]        hex4,
   output logic [6:0]        hex5    // bits 23:20
);

   // active-low, bit order gfedcba
   function automatic logic [6:0] seg7(input logic [3:0] nib);
      case (nib)
         4'h0: seg7 = 7'h40;
         4'h1: seg7 = 7'h79;
         4'h2: seg7 = 7'h24;
         4'h3: seg7 = 7'h30;
         4'h4: seg7 = 7'h19;
         4'h5: seg7 = 7'h12;
         4'h6: seg7 = 7'h02;
         4'h7: seg7 = 7'h78;
         4'h8: seg7 = 7'h00;
         4'h9: seg7 = 7'h10;
         4'ha: seg7 = 7'h08;
         4'hb: seg7 = 7'h03;  // lower-case b
         4'hc: seg7 = 7'h46;
         4'hd: seg7 = 7'h21;  // lower-case d
         4'he: seg7 = 7'h06;
         default: seg7 = 7'h0e;  // f
      endcase
   endfunction

   assign hex0 = seg7(value[3:0]);
   assign hex1 = seg7(value[7:4]);
   assign hex2 = seg7(value[11:8]);
   assign hex3 = seg7(value[15:12]);
   assign hex4 = seg7(value[19:16]);
   assign hex5 = seg7(value[23:20]);

endmodule

// ==== logic/mem_demo_top.sv ====
`timescale 1ns/1ns
// memory transfer demo top
// sequencer drives the router, router drives sram and register file, display shows rdata
module mem_demo_top #(
   parameter int data_w  = xfer_pkg::DATA_W,
   parameter int sram_aw = xfer_pkg::SRAM_AW,
   parameter int fr_aw   = xfer_pkg::FR_AW
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                start,
   input  xfer_pkg::xfer_cmd_e cmd,
   input  logic [sram_aw-1:0]  sram_addr,
   input  logic [fr_aw-1:0]    reg_addr,
   input  logic [data_w-1:0]   wdata,
   output logic                busy,
   output logic                init_done,
   output logic [data_w-1:0]   rdata,
   output logic [6:0]          hex0,
   output logic [6:0]          hex1,
   output logic [6:0]          hex2,
   output logic [6:0]          hex3,
   output logic [6:0]          hex4,
   output logic [6:0]          hex5
);
   import xfer_pkg::*;

   // sequencer -> router
   logic               op_valid;
   xfer_cmd_e          op;
   logic [sram_aw-1:0] op_sram_addr;
   logic [fr_aw-1:0]   op_reg_addr;
   logic [data_w-1:0]  op_wdata;
   logic               op_done;
   // router <-> sram
   logic               sram_we;
   logic               sram_re;
   logic [sram_aw-1:0] sram_bus_addr;
   logic [data_w-1:0]  sram_wdata;
   logic [data_w-1:0]  sram_rdata;
   // router <-> register file
   logic               fr_we;
   logic               fr_re;
   logic [fr_aw-1:0]   fr_bus_addr;
   logic [data_w-1:0]  fr_wdata;
   logic [data_w-1:0]  fr_rdata;

   xfer_sequencer #(.data_w(data_w), .sram_aw(sram_aw), .fr_aw(fr_aw)) seq_i (
      .clk, .rst, .start, .cmd, .sram_addr, .reg_addr, .wdata, .op_done,
      .op_valid, .op, .op_sram_addr, .op_reg_addr, .op_wdata, .busy, .init_done
   );

   bus_router #(.data_w(data_w), .sram_aw(sram_aw), .fr_aw(fr_aw)) router_i (
      .clk, .rst, .op_valid, .op, .op_sram_addr, .op_reg_addr, .op_wdata,
      .sram_rdata, .fr_rdata, .op_done, .sram_we, .sram_re,
      .sram_addr(sram_bus_addr), .sram_wdata, .fr_we, .fr_re,
      .fr_addr(fr_bus_addr), .fr_wdata, .rdata
   );

   sram #(.data_w(data_w), .sram_aw(sram_aw)) sram_i (
      .clk, .we(sram_we), .re(sram_re), .addr(sram_bus_addr),
      .wdata(sram_wdata), .rdata(sram_rdata)
   );

   register_file #(.data_w(data_w), .fr_aw(fr_aw)) fr_i (
      .clk, .rst, .we(fr_we), .re(fr_re), .addr(fr_bus_addr),
      .wdata(fr_wdata), .rdata(fr_rdata)
   );

   hex_display #(.data_w(data_w)) hex_i (
      .value(rdata), .hex0, .hex1, .hex2, .hex3, .hex4, .hex5
   );

endmodule

// ==== dv/mem_demo_checker.sv ====
`timescale 1ns/1ns
// router strobe checker
// bound into bus_router, flags overlapping strobes and strobes during reset
module mem_demo_checker (
   input logic clk,
   input logic rst,
   input logic sram_we,
   input logic sram_re,
   input logic fr_we,
   input logic fr_re
);

   int   fail_count      = 0;     // seen by the testbench
   logic first_edge_seen = 1'b0;  // op_valid still unknown before the first reset edge

   always @(posedge clk) begin
      first_edge_seen <= 1'b1;
   end

   // single-port sram, one access per cycle
   sram_strobe_excl: assert property (@(posedge clk) disable iff (rst)
      !(sram_we && sram_re))
      else begin
         fail_count++;
         $error("sram write and read strobes in the same cycle");
      end

   fr_strobe_excl: assert property (@(posedge clk) disable iff (rst)
      !(fr_we && fr_re))
      else begin
         fail_count++;
         $error("register file write and read strobes in the same cycle");
      end

   quiet_in_reset: assert property (@(posedge clk)
      rst && first_edge_seen |-> !(sram_we || sram_re || fr_we || fr_re))
      else begin
         fail_count++;
         $error("memory strobe active during reset");
      end

endmodule

// ==== dv/mem_demo_tb.sv ====
`timescale 1ns/1ns
// memory transfer demo testbench
// file-driven commands into mem_demo_top, checks rdata, hex digits and busy handling
module mem_demo_tb;
   import xfer_pkg::*;

   localparam int    data_w     = DATA_W;
   localparam int    sram_aw    = SRAM_AW;
   localparam int    fr_aw      = FR_AW;
   localparam int    sram_depth = 1 << sram_aw;
   localparam string vec_file   = "dv/mem_demo_input.txt";

   logic               clk;
   logic               rst;
   logic               start;
   xfer_cmd_e          cmd;
   logic [sram_aw-1:0] sram_addr;
   logic [fr_aw-1:0]   reg_addr;
   logic [data_w-1:0]  wdata;
   logic               busy;
   logic               init_done;
   logic [data_w-1:0]  rdata;
   logic [6:0]         hex_out [6];  // hex0 .. hex5

   // one entry per vector line
   string             vec_name  [$];
   logic [2:0]        vec_cmd   [$];
   logic [31:0]       vec_saddr [$];
   logic [31:0]       vec_raddr [$];
   logic [data_w-1:0] vec_wdata [$];
   logic [data_w-1:0] vec_exp   [$];
   bit                vec_read  [$];  // expected column present
   bit                vec_extra [$];  // extra start edge while busy
   int                vec_count      = 0;
   bit                vectors_loaded = 1'b0;

   mem_demo_top #(.data_w(data_w), .sram_aw(sram_aw), .fr_aw(fr_aw)) dut_i (
      .clk, .rst, .start, .cmd, .sram_addr, .reg_addr, .wdata, .busy, .init_done, .rdata,
      .hex0(hex_out[0]), .hex1(hex_out[1]), .hex2(hex_out[2]),
      .hex3(hex_out[3]), .hex4(hex_out[4]), .hex5(hex_out[5])
   );

   bind bus_router mem_demo_checker checker_i (
      .clk(clk), .rst(rst), .sram_we(sram_we), .sram_re(sram_re), .fr_we(fr_we), .fr_re(fr_re)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("FAIL %s expected %h actual %h", what, expected, actual));
      end
   endtask

   // active-low digits from the standard gfedcba lit-segment table
   function automatic logic [6:0] seg_expected(input logic [3:0] nib);
      logic [6:0] lit;
      case (nib)
         4'h0: lit = 7'h3f;
         4'h1: lit = 7'h06;
         4'h2: lit = 7'h5b;
         4'h3: lit = 7'h4f;
         4'h4: lit = 7'h66;
         4'h5: lit = 7'h6d;
         4'h6: lit = 7'h7d;
         4'h7: lit = 7'h07;
         4'h8: lit = 7'h7f;
         4'h9: lit = 7'h6f;
         4'ha: lit = 7'h77;
         4'hb: lit = 7'h7c;
         4'hc: lit = 7'h39;
         4'hd: lit = 7'h5e;
         4'he: lit = 7'h79;
         default: lit = 7'h71;
      endcase
      return ~lit;
   endfunction

   function automatic int cmd_code(input string name);
      if (name == "idle")            return int'(CMD_IDLE);
      else if (name == "to_sram")    return int'(CMD_TO_SRAM);
      else if (name == "to_fr")      return int'(CMD_TO_FR);
      else if (name == "from_sram")  return int'(CMD_FROM_SRAM);
      else if (name == "from_fr")    return int'(CMD_FROM_FR);
      else if (name == "fr_to_sram") return int'(CMD_FR_TO_SRAM);
      else if (name == "sram_to_fr") return int'(CMD_SRAM_TO_FR);
      else                           return -1;  // unknown mnemonic
   endfunction

   task automatic load_vectors();
      int                fd;
      int                fields;
      int                code;
      int                extra;
      string             line;
      string             name_s;
      string             cmd_s;
      string             exp_s;
      logic [31:0]       sa;
      logic [31:0]       ra;
      logic [data_w-1:0] wd;
      logic [data_w-1:0] ev;
      fd = $fopen(vec_file, "r");
      if (fd == 0) begin
         abort_run({"cannot open the stimulus file ", vec_file});
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments and blank lines
               fields = $sscanf(line, "%s %s %h %h %h %s %d",
                                name_s, cmd_s, sa, ra, wd, exp_s, extra);
               code = cmd_code(cmd_s);
               if (fields != 7 || code < 0) begin
                  abort_run({"malformed stimulus line: ", line});
               end
               ev = '0;
               if (exp_s != "x") begin
                  fields = $sscanf(exp_s, "%h", ev);
               end
               vec_name.push_back(name_s);
               vec_cmd.push_back(code[2:0]);
               vec_saddr.push_back(sa);
               vec_raddr.push_back(ra);
               vec_wdata.push_back(wd);
               vec_exp.push_back(ev);
               vec_read.push_back(exp_s != "x");
               vec_extra.push_back(extra != 0);
            end
         end
         $fclose(fd);
         vec_count = vec_name.size();
      end
   endtask

   // start edge on a falling clock and an optional second edge while busy, then wait for idle
   task automatic issue_command(input xfer_cmd_e c, input logic [sram_aw-1:0] sa,
                                input logic [fr_aw-1:0] ra, input logic [data_w-1:0] wd,
                                input bit extra);
      @(negedge clk);
      cmd       = c;
      sram_addr = sa;
      reg_addr  = ra;
      wdata     = wd;
      start     = 1'b1;
      @(negedge clk);
      start = 1'b0;
      if (!busy) begin
         abort_run("busy did not rise after a start edge");
      end else if (extra) begin
         @(negedge clk);
         if (!busy) begin
            abort_run("busy fell before the extra start edge could be given");
         end else begin
            wdata = ~wd;  // a taken edge would write this instead
            if (c == CMD_FROM_SRAM || c == CMD_FROM_FR) begin
               sram_addr = ~sa;  // a taken read would fetch another word
               reg_addr  = ~ra;
            end
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
         end
      end
      while (busy) @(negedge clk);
      if (extra) begin
         repeat (3) @(negedge clk);  // a stray command would land within the longest span
      end
   endtask

   task automatic check_display(input string name, input logic [data_w-1:0] word);
      int d;
      check_value({name, " rdata"}, word, rdata);
      for (d = 0; d < 6; d++) begin
         check_value($sformatf("%s hex%0d", name, d), 32'(seg_expected(word[4*d +: 4])),
                     32'(hex_out[d]));
      end
   endtask

   initial begin : stimulus
      int idx;
      rst       = 1'b1;
      start     = 1'b0;
      cmd       = CMD_IDLE;
      sram_addr = '0;
      reg_addr  = '0;
      wdata     = '0;
      load_vectors();
      vectors_loaded = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_value("reset busy", 32'd0, 32'(busy));
      check_value("reset init_done", 32'd0, 32'(init_done));
      check_display("reset", '0);  // all digits show 0
      // first edge starts the sram fill
      issue_command(CMD_IDLE, '0, '0, '0, 1'b0);
      check_value("fill init_done", 32'd1, 32'(init_done));
      for (idx = 0; idx < vec_count; idx++) begin
         issue_command(xfer_cmd_e'(vec_cmd[idx]), vec_saddr[idx][sram_aw-1:0],
                       vec_raddr[idx][fr_aw-1:0], vec_wdata[idx], vec_extra[idx]);
         check_value({vec_name[idx], " init_done"}, 32'd1, 32'(init_done));
         if (vec_read[idx]) begin
            check_display(vec_name[idx], vec_exp[idx]);
         end
      end
      $display("Simulation passed");
      $finish;
   end

   // limit scales with fill depth and vector count
   initial begin : watchdog
      wait (vectors_loaded);
      repeat (2 * (sram_depth + 10 + 10 * vec_count)) @(posedge clk);
      abort_run("timeout: busy never cleared");
   end

   initial begin : assertion_watch
      wait (dut_i.router_i.checker_i.fail_count != 0);
      abort_run("a router strobe assertion failed");
   end

endmodule

// ==== dv/mem_demo_input.txt ====
# name  cmd  sram_addr  reg_addr  wdata  expected_rdata (x when not a read)  extra_start_while_busy
# addresses and data in hex, fill leaves ~addr in bits 6:0 of each sram word
fill_a00    from_sram   00 00 00000000 0000007f 0
fill_a01    from_sram   01 00 00000000 0000007e 0
fill_a55    from_sram   55 00 00000000 0000002a 0
fill_a7f    from_sram   7f 00 00000000 00000000 0
wr_sram_10  to_sram     10 00 a5c3e1f7 x 0
rd_sram_10  from_sram   10 00 00000000 a5c3e1f7 0
wr_fr_07    to_fr       00 07 12345678 x 0
rd_fr_07    from_fr     00 07 00000000 12345678 0
wr_fr_0b    to_fr       00 0b 9abcdef0 x 0
rd_fr_0b    from_fr     00 0b 00000000 9abcdef0 0
cp_s2f      sram_to_fr  55 03 00000000 x 0
rd_cp_s2f   from_fr     00 03 00000000 0000002a 0
cp_f2s      fr_to_sram  20 07 00000000 x 0
rd_cp_f2s   from_sram   20 00 00000000 12345678 0
wr_r0       to_fr       00 00 5a5a0ff0 x 0
rd_r0       from_fr     00 00 00000000 00000000 0
wr_busy_30  to_sram     30 00 0f1e2d3c x 1
rd_busy_30  from_sram   30 00 00000000 0f1e2d3c 0
rd_busy_fr  from_fr     00 0b 00000000 9abcdef0 1

// ==== files.f ====
common/xfer_pkg.sv
memory/sram.sv
memory/register_file.sv
logic/xfer_sequencer.sv
logic/bus_router.sv
logic/hex_display.sv
logic/mem_demo_top.sv
dv/mem_demo_checker.sv
dv/mem_demo_tb.sv

// ==== Makefile ====
# Verilator flow for the memory transfer demo, run from the project root

VERILATOR ?= verilator
TOP       ?= mem_demo_tb
VFLAGS    ?= --timing --assert
OBJ_DIR   ?= obj_dir
SIMFLAGS  ?= +verilator+error+limit+10
FILELIST  ?= files.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the verdict comes from the printed output, the run leaves no log behind
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
